// ==== verilog/rs_pkg.sv ====
package rs_pkg;

    // datapath width of the core
    parameter int xlen = 32;

    typedef logic [xlen-1:0] imm_t;
    typedef logic [31:0] instr_t;

    // rv32i major opcodes, bits 6:0 of the instruction
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011
    } opcode_e;

    // funct3 codes that steer the immediate or the unit choice
    parameter logic [2:0] funct3_slt  = 3'b010;
    parameter logic [2:0] funct3_sltu = 3'b011;
    parameter logic [2:0] funct3_sr   = 3'b101;

endpackage

// ==== verilog/rs_dispatch_decode.sv ====
module rs_dispatch_decode #(
    parameter int NUM_PHYS_REGS = 64
) (
    input  rs_pkg::instr_t                    i_inst,
    input  logic [$clog2(NUM_PHYS_REGS)-1:0]  i_phys_rd,
    input  logic [$clog2(NUM_PHYS_REGS)-1:0]  i_phys_rs1,
    input  logic [$clog2(NUM_PHYS_REGS)-1:0]  i_phys_rs2,
    output logic                              o_decode_ok,
    output rs_pkg::opcode_e                   o_opcode,
    output rs_pkg::imm_t                      o_imm,
    output logic                              o_regf_we,
    output logic                              o_aluc,
    output logic                              o_use_rs1,
    output logic                              o_use_rs2,
    output logic [$clog2(NUM_PHYS_REGS)-1:0]  o_phys_rd,
    output logic [$clog2(NUM_PHYS_REGS)-1:0]  o_phys_rs1,
    output logic [$clog2(NUM_PHYS_REGS)-1:0]  o_phys_rs2
);
    import rs_pkg::*;

    logic [2:0] funct3;
    logic       is_slt;
    imm_t       imm_i;
    imm_t       imm_b;
    imm_t       imm_s;

    assign funct3 = i_inst[14:12];
    assign is_slt = (funct3 == funct3_slt) || (funct3 == funct3_sltu);

    // the standard immediate formats
    assign imm_i = {{21{i_inst[31]}}, i_inst[30:20]};
    assign imm_b = {{20{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
    assign imm_s = {{21{i_inst[31]}}, i_inst[30:25], i_inst[11:7]};

    always_comb
    begin
        o_decode_ok = 1'b1;
        o_opcode    = opcode_e'(i_inst[6:0]);
        o_imm       = '0;
        o_regf_we   = 1'b1;
        o_aluc      = 1'b1;
        o_use_rs1   = 1'b0;
        o_use_rs2   = 1'b0;
        case (o_opcode)
            op_lui, op_auipc:
            begin
                o_imm = {i_inst[31:12], 12'h000};
            end
            op_jal:
            begin
                // link value is pc plus one instruction
                o_imm = 32'd4;
            end
            op_jalr, op_load:
            begin
                o_imm     = imm_i;
                o_use_rs1 = 1'b1;
            end
            op_imm:
            begin
                // shift right keeps only the shamt field, bit 30 picks arithmetic
                o_imm     = (funct3 == funct3_sr) ? {{27{i_inst[31]}}, i_inst[24:20]} : imm_i;
                o_aluc    = !is_slt;
                o_use_rs1 = 1'b1;
            end
            op_branch:
            begin
                o_imm     = imm_b;
                o_regf_we = 1'b0;
                o_aluc    = 1'b0;
                o_use_rs1 = 1'b1;
                o_use_rs2 = 1'b1;
            end
            op_store:
            begin
                o_imm     = imm_s;
                o_regf_we = 1'b0;
                o_use_rs1 = 1'b1;
                o_use_rs2 = 1'b1;
            end
            op_reg:
            begin
                o_aluc    = !is_slt;
                o_use_rs1 = 1'b1;
                o_use_rs2 = 1'b1;
            end
            default:
            begin
                o_decode_ok = 1'b0;
                o_regf_we   = 1'b0;
                o_aluc      = 1'b0;
            end
        endcase
    end

    // unused registers go out as zero
    assign o_phys_rd  = o_regf_we ? i_phys_rd : '0;
    assign o_phys_rs1 = o_use_rs1 ? i_phys_rs1 : '0;
    assign o_phys_rs2 = o_use_rs2 ? i_phys_rs2 : '0;

    // only the two-source formats may claim rs2
    always_comb
    begin
        if (o_use_rs2)
        begin
            a_use_rs2_fmt: assert (i_inst[6:0] == op_branch || i_inst[6:0] == op_store
                                   || i_inst[6:0] == op_reg)
                else $error("rs2 used by opcode %b", i_inst[6:0]);
        end
    end

endmodule

// ==== verilog/rs_slot_alloc.sv ====
module rs_slot_alloc #(
    parameter int STATION_DEPTH = 16
) (
    input  logic                             clk,
    input  logic                             i_rst,
    input  logic                             i_flush,
    input  logic                             i_dispatch_valid,
    input  logic                             i_decode_ok,
    input  logic                             i_remove,
    input  logic [$clog2(STATION_DEPTH)-1:0] i_remove_idx,
    output logic                             o_alloc_we,
    output logic [$clog2(STATION_DEPTH)-1:0] o_alloc_idx,
    output logic [STATION_DEPTH-1:0]         o_busy,
    output logic                             o_full
);

    localparam int IDX_W = $clog2(STATION_DEPTH);

    logic [STATION_DEPTH-1:0] busy_q;

    // lowest clear bit wins, scanned from the top down
    always_comb
    begin
        o_alloc_idx = '0;
        for (int i = STATION_DEPTH - 1; i >= 0; i--)
        begin
            if (!busy_q[i])
            begin
                o_alloc_idx = IDX_W'(i);
            end
        end
    end

    // a removal this cycle does not help this cycle's dispatch
    assign o_full     = &busy_q;
    assign o_alloc_we = i_dispatch_valid && i_decode_ok && !o_full;
    assign o_busy     = busy_q;

    always_ff @(posedge clk)
    begin
        if (i_rst || i_flush)
        begin
            busy_q <= '0;
        end
        else
        begin
            if (i_remove)
            begin
                busy_q[i_remove_idx] <= 1'b0;
            end
            if (o_alloc_we)
            begin
                busy_q[o_alloc_idx] <= 1'b1;
            end
        end
    end

    a_alloc_free: assert property (@(posedge clk) disable iff (i_rst)
        o_alloc_we |-> !busy_q[o_alloc_idx])
        else $error("allocation into busy slot %0d", o_alloc_idx);

    // the issue stage may only retire what it was offered
    a_remove_busy: assert property (@(posedge clk) disable iff (i_rst)
        i_remove |-> busy_q[i_remove_idx])
        else $error("removal of idle slot %0d", i_remove_idx);

endmodule

// ==== verilog/rs_entry_table.sv ====
module rs_entry_table #(
    parameter int STATION_DEPTH = 16,
    parameter int NUM_PHYS_REGS = 64,
    parameter int ROB_SIZE      = 16
) (
    input  logic                             clk,
    input  logic                             i_alloc_we,
    input  logic [$clog2(STATION_DEPTH)-1:0] i_alloc_idx,
    input  logic [STATION_DEPTH-1:0]         i_busy,
    input  rs_pkg::opcode_e                  i_opcode,
    input  rs_pkg::imm_t                     i_imm,
    input  logic                             i_regf_we,
    input  logic                             i_aluc,
    input  logic                             i_use_rs1,
    input  logic                             i_use_rs2,
    input  logic [$clog2(NUM_PHYS_REGS)-1:0] i_phys_rd,
    input  logic [$clog2(NUM_PHYS_REGS)-1:0] i_phys_rs1,
    input  logic [$clog2(NUM_PHYS_REGS)-1:0] i_phys_rs2,
    input  logic [$clog2(ROB_SIZE)-1:0]      i_rob_index,
    input  logic [NUM_PHYS_REGS-1:0]         i_phys_valid,
    input  logic [$clog2(STATION_DEPTH)-1:0] i_rd_idx,
    output logic [STATION_DEPTH-1:0]         o_ready,
    output rs_pkg::opcode_e                  o_rd_opcode,
    output rs_pkg::imm_t                     o_rd_imm,
    output logic [$clog2(NUM_PHYS_REGS)-1:0] o_rd_phys_rd,
    output logic [$clog2(NUM_PHYS_REGS)-1:0] o_rd_phys_rs1,
    output logic [$clog2(NUM_PHYS_REGS)-1:0] o_rd_phys_rs2,
    output logic [$clog2(ROB_SIZE)-1:0]      o_rd_rob_index,
    output logic                             o_rd_regf_we,
    output logic                             o_rd_aluc
);
    import rs_pkg::*;

    localparam int PREG_W = $clog2(NUM_PHYS_REGS);
    localparam int ROB_W  = $clog2(ROB_SIZE);

    opcode_e            opcode_q   [STATION_DEPTH];
    imm_t               imm_q      [STATION_DEPTH];
    logic [PREG_W-1:0]  phys_rd_q  [STATION_DEPTH];
    logic [PREG_W-1:0]  phys_rs1_q [STATION_DEPTH];
    logic [PREG_W-1:0]  phys_rs2_q [STATION_DEPTH];
    logic [ROB_W-1:0]   rob_q      [STATION_DEPTH];
    logic [STATION_DEPTH-1:0] regf_we_q;
    logic [STATION_DEPTH-1:0] aluc_q;
    logic [STATION_DEPTH-1:0] use_rs1_q;
    logic [STATION_DEPTH-1:0] use_rs2_q;

    // payload only, validity lives in the busy vector
    always_ff @(posedge clk)
    begin
        if (i_alloc_we)
        begin
            opcode_q[i_alloc_idx]   <= i_opcode;
            imm_q[i_alloc_idx]      <= i_imm;
            phys_rd_q[i_alloc_idx]  <= i_phys_rd;
            phys_rs1_q[i_alloc_idx] <= i_phys_rs1;
            phys_rs2_q[i_alloc_idx] <= i_phys_rs2;
            rob_q[i_alloc_idx]      <= i_rob_index;
            regf_we_q[i_alloc_idx]  <= i_regf_we;
            aluc_q[i_alloc_idx]     <= i_aluc;
            use_rs1_q[i_alloc_idx]  <= i_use_rs1;
            use_rs2_q[i_alloc_idx]  <= i_use_rs2;
        end
    end

    for (genvar g = 0; g < STATION_DEPTH; g++)
    begin : g_ready
        // a source the instruction does not read never holds it back
        assign o_ready[g] = i_busy[g]
                            && (!use_rs1_q[g] || i_phys_valid[phys_rs1_q[g]])
                            && (!use_rs2_q[g] || i_phys_valid[phys_rs2_q[g]]);

        a_ready_busy: assert property (@(posedge clk) $rose(o_ready[g]) |-> i_busy[g])
            else $error("slot %0d ready while idle", g);
    end

    // issue side read port
    assign o_rd_opcode    = opcode_q[i_rd_idx];
    assign o_rd_imm       = imm_q[i_rd_idx];
    assign o_rd_phys_rd   = phys_rd_q[i_rd_idx];
    assign o_rd_phys_rs1  = phys_rs1_q[i_rd_idx];
    assign o_rd_phys_rs2  = phys_rs2_q[i_rd_idx];
    assign o_rd_rob_index = rob_q[i_rd_idx];
    assign o_rd_regf_we   = regf_we_q[i_rd_idx];
    assign o_rd_aluc      = aluc_q[i_rd_idx];

endmodule

// ==== verilog/reservation_station.sv ====
module reservation_station #(
    parameter int STATION_DEPTH = 16,
    parameter int NUM_PHYS_REGS = 64,
    parameter int ROB_SIZE      = 16
) (
    input  logic                             clk,
    input  logic                             i_rst,
    input  logic                             i_flush,
    input  logic                             i_dispatch_valid,
    input  rs_pkg::instr_t                   i_inst,
    input  logic [$clog2(NUM_PHYS_REGS)-1:0] i_phys_rd,
    input  logic [$clog2(NUM_PHYS_REGS)-1:0] i_phys_rs1,
    input  logic [$clog2(NUM_PHYS_REGS)-1:0] i_phys_rs2,
    input  logic [$clog2(ROB_SIZE)-1:0]      i_rob_index,
    input  logic                             i_remove,
    input  logic [$clog2(STATION_DEPTH)-1:0] i_remove_idx,
    input  logic [NUM_PHYS_REGS-1:0]         i_phys_valid,
    input  logic [$clog2(STATION_DEPTH)-1:0] i_rd_idx,
    output logic                             o_full,
    output logic [STATION_DEPTH-1:0]         o_ready,
    output rs_pkg::opcode_e                  o_rd_opcode,
    output rs_pkg::imm_t                     o_rd_imm,
    output logic [$clog2(NUM_PHYS_REGS)-1:0] o_rd_phys_rd,
    output logic [$clog2(NUM_PHYS_REGS)-1:0] o_rd_phys_rs1,
    output logic [$clog2(NUM_PHYS_REGS)-1:0] o_rd_phys_rs2,
    output logic [$clog2(ROB_SIZE)-1:0]      o_rd_rob_index,
    output logic                             o_rd_regf_we,
    output logic                             o_rd_aluc
);
    import rs_pkg::*;

    localparam int PREG_W = $clog2(NUM_PHYS_REGS);
    localparam int IDX_W  = $clog2(STATION_DEPTH);

    logic                     decode_ok;
    opcode_e                  opcode;
    imm_t                     imm;
    logic                     regf_we;
    logic                     aluc;
    logic                     use_rs1;
    logic                     use_rs2;
    logic [PREG_W-1:0]        dec_phys_rd;
    logic [PREG_W-1:0]        dec_phys_rs1;
    logic [PREG_W-1:0]        dec_phys_rs2;
    logic                     alloc_we;
    logic [IDX_W-1:0]         alloc_idx;
    logic [STATION_DEPTH-1:0] busy;

    rs_dispatch_decode #(
        .NUM_PHYS_REGS (NUM_PHYS_REGS)
    ) rs_dispatch_decode_inst (
        .i_inst      (i_inst),
        .i_phys_rd   (i_phys_rd),
        .i_phys_rs1  (i_phys_rs1),
        .i_phys_rs2  (i_phys_rs2),
        .o_decode_ok (decode_ok),
        .o_opcode    (opcode),
        .o_imm       (imm),
        .o_regf_we   (regf_we),
        .o_aluc      (aluc),
        .o_use_rs1   (use_rs1),
        .o_use_rs2   (use_rs2),
        .o_phys_rd   (dec_phys_rd),
        .o_phys_rs1  (dec_phys_rs1),
        .o_phys_rs2  (dec_phys_rs2)
    );

    rs_slot_alloc #(
        .STATION_DEPTH (STATION_DEPTH)
    ) rs_slot_alloc_inst (
        .clk              (clk),
        .i_rst            (i_rst),
        .i_flush          (i_flush),
        .i_dispatch_valid (i_dispatch_valid),
        .i_decode_ok      (decode_ok),
        .i_remove         (i_remove),
        .i_remove_idx     (i_remove_idx),
        .o_alloc_we       (alloc_we),
        .o_alloc_idx      (alloc_idx),
        .o_busy           (busy),
        .o_full           (o_full)
    );

    rs_entry_table #(
        .STATION_DEPTH (STATION_DEPTH),
        .NUM_PHYS_REGS (NUM_PHYS_REGS),
        .ROB_SIZE      (ROB_SIZE)
    ) rs_entry_table_inst (
        .clk            (clk),
        .i_alloc_we     (alloc_we),
        .i_alloc_idx    (alloc_idx),
        .i_busy         (busy),
        .i_opcode       (opcode),
        .i_imm          (imm),
        .i_regf_we      (regf_we),
        .i_aluc         (aluc),
        .i_use_rs1      (use_rs1),
        .i_use_rs2      (use_rs2),
        .i_phys_rd      (dec_phys_rd),
        .i_phys_rs1     (dec_phys_rs1),
        .i_phys_rs2     (dec_phys_rs2),
        .i_rob_index    (i_rob_index),
        .i_phys_valid   (i_phys_valid),
        .i_rd_idx       (i_rd_idx),
        .o_ready        (o_ready),
        .o_rd_opcode    (o_rd_opcode),
        .o_rd_imm       (o_rd_imm),
        .o_rd_phys_rd   (o_rd_phys_rd),
        .o_rd_phys_rs1  (o_rd_phys_rs1),
        .o_rd_phys_rs2  (o_rd_phys_rs2),
        .o_rd_rob_index (o_rd_rob_index),
        .o_rd_regf_we   (o_rd_regf_we),
        .o_rd_aluc      (o_rd_aluc)
    );

endmodule

// ==== tb/tb_reservation_station.sv ====
module tb_reservation_station;
    import rs_pkg::*;

    localparam int DEPTH = 16;
    // about 230 cycles of tests, the limit leaves a wide margin
    localparam int CYCLE_LIMIT = 2000;

    logic clk;
    logic i_rst, i_flush, i_dispatch_valid, i_remove;
    logic [31:0] i_inst;
    logic [5:0] i_phys_rd, i_phys_rs1, i_phys_rs2;
    logic [3:0] i_rob_index, i_remove_idx;
    logic [3:0] i_rd_idx = 4'd0;
    logic [63:0] i_phys_valid;
    logic o_full, o_rd_regf_we, o_rd_aluc;
    logic [15:0] o_ready;
    opcode_e o_rd_opcode;
    imm_t o_rd_imm;
    logic [5:0] o_rd_phys_rd, o_rd_phys_rs1, o_rd_phys_rs2;
    logic [3:0] o_rd_rob_index;

    // reference model of the table
    logic [15:0] m_busy, m_we, m_aluc, m_use1, m_use2, exp_ready;
    logic [6:0] m_opcode [DEPTH];
    logic [31:0] m_imm [DEPTH];
    logic [5:0] m_prd [DEPTH];
    logic [5:0] m_prs1 [DEPTH];
    logic [5:0] m_prs2 [DEPTH];
    logic [3:0] m_rob [DEPTH];
    logic exp_full;

    integer seed = 32'haa15;
    int errors = 0;
    int tests = 0;
    int failed_tests = 0;
    int test_start_errors = 0;
    int cycle_count = 0;
    logic [31:0] r;
    logic [3:0] k;
    logic [6:0] fill_ops [16] = '{op_lui, op_jalr, op_branch, op_load, op_store, op_imm, op_reg,
                                  op_jal, op_auipc, op_reg, op_branch, op_imm, op_store,
                                  op_lui, op_load, op_reg};

    reservation_station reservation_station_inst (.*);

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT)
        begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAILED");
            $finish;
        end
    end

    // the read port walks over all slots
    always @(posedge clk)
    begin
        i_rd_idx <= i_rd_idx + 4'd1;
    end

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    function automatic logic [31:0] make_inst(input logic [6:0] op, input logic [2:0] f3);
        logic [31:0] v;
        v = rand32();
        return {v[31:15], f3, v[11:7], op};
    endfunction

    function automatic logic [31:0] expected_imm(input logic [31:0] inst);
        case (inst[6:0])
            op_lui, op_auipc: return {inst[31:12], 12'h000};
            op_jal: return 32'd4;
            op_branch: return {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            op_store: return {{20{inst[31]}}, inst[31:25], inst[11:7]};
            op_reg: return 32'd0;
            op_imm: return (inst[14:12] == 3'b101) ? {{27{inst[31]}}, inst[24:20]}
                                                   : {{20{inst[31]}}, inst[31:20]};
            default: return {{20{inst[31]}}, inst[31:20]};
        endcase
    endfunction

    function automatic logic [3:0] lowest_free(input logic [15:0] busy);
        logic [3:0] idx;
        logic found;
        idx = 4'd0;
        found = 1'b0;
        for (int s = 0; s < DEPTH; s++)
        begin
            if (!found && !busy[s])
            begin
                idx = 4'(s);
                found = 1'b1;
            end
        end
        return idx;
    endfunction

    assign exp_full = &m_busy;

    always_comb
    begin
        for (int s = 0; s < DEPTH; s++)
        begin
            exp_ready[s] = m_busy[s];
            if (m_use1[s] && !i_phys_valid[m_prs1[s]])
                exp_ready[s] = 1'b0;
            if (m_use2[s] && !i_phys_valid[m_prs2[s]])
                exp_ready[s] = 1'b0;
        end
    end

    always @(posedge clk)
    begin : reference_model
        logic [15:0] busy_next;
        logic [6:0] op;
        logic known, use1, use2, we, slt;
        logic [3:0] slot;
        op = i_inst[6:0];
        known = op inside {op_lui, op_auipc, op_jal, op_jalr, op_branch, op_load, op_store,
                           op_imm, op_reg};
        use1 = known && !(op inside {op_lui, op_auipc, op_jal});
        use2 = op inside {op_branch, op_store, op_reg};
        we = known && !(op inside {op_branch, op_store});
        // funct3 010 and 011 are the set-less-than pair
        slt = (i_inst[14:13] == 2'b01) && (op == op_imm || op == op_reg);
        busy_next = m_busy;
        if (i_rst || i_flush)
            busy_next = '0;
        else
        begin
            if (i_remove)
                busy_next[i_remove_idx] = 1'b0;
            if (i_dispatch_valid && known && !exp_full)
            begin
                slot = lowest_free(m_busy);
                busy_next[slot] = 1'b1;
                m_opcode[slot] <= op;
                m_imm[slot] <= expected_imm(i_inst);
                m_prd[slot] <= we ? i_phys_rd : 6'd0;
                m_prs1[slot] <= use1 ? i_phys_rs1 : 6'd0;
                m_prs2[slot] <= use2 ? i_phys_rs2 : 6'd0;
                m_rob[slot] <= i_rob_index;
                m_we[slot] <= we;
                m_aluc[slot] <= !(op == op_branch || slt);
                m_use1[slot] <= use1;
                m_use2[slot] <= use2;
            end
        end
        m_busy <= busy_next;
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("Mismatch at time %0t: %s is %h, expected %h", $time, name, got, exp);
        errors++;
    endtask

    a_full: assert property (@(posedge clk) disable iff (i_rst) o_full == exp_full)
        else report_mismatch("o_full", 32'($sampled(o_full)), 32'($sampled(exp_full)));
    a_ready: assert property (@(posedge clk) disable iff (i_rst) o_ready == exp_ready)
        else report_mismatch("o_ready", 32'($sampled(o_ready)), 32'($sampled(exp_ready)));
    a_opcode: assert property (@(posedge clk) disable iff (i_rst)
        m_busy[i_rd_idx] |-> o_rd_opcode == m_opcode[i_rd_idx])
        else report_mismatch("o_rd_opcode", 32'($sampled(o_rd_opcode)),
                             32'($sampled(m_opcode[i_rd_idx])));
    a_imm: assert property (@(posedge clk) disable iff (i_rst)
        m_busy[i_rd_idx] |-> o_rd_imm == m_imm[i_rd_idx])
        else report_mismatch("o_rd_imm", $sampled(o_rd_imm), $sampled(m_imm[i_rd_idx]));
    a_prd: assert property (@(posedge clk) disable iff (i_rst)
        m_busy[i_rd_idx] |-> o_rd_phys_rd == m_prd[i_rd_idx])
        else report_mismatch("o_rd_phys_rd", 32'($sampled(o_rd_phys_rd)),
                             32'($sampled(m_prd[i_rd_idx])));
    a_prs1: assert property (@(posedge clk) disable iff (i_rst)
        m_busy[i_rd_idx] |-> o_rd_phys_rs1 == m_prs1[i_rd_idx])
        else report_mismatch("o_rd_phys_rs1", 32'($sampled(o_rd_phys_rs1)),
                             32'($sampled(m_prs1[i_rd_idx])));
    a_prs2: assert property (@(posedge clk) disable iff (i_rst)
        m_busy[i_rd_idx] |-> o_rd_phys_rs2 == m_prs2[i_rd_idx])
        else report_mismatch("o_rd_phys_rs2", 32'($sampled(o_rd_phys_rs2)),
                             32'($sampled(m_prs2[i_rd_idx])));
    a_rob: assert property (@(posedge clk) disable iff (i_rst)
        m_busy[i_rd_idx] |-> o_rd_rob_index == m_rob[i_rd_idx])
        else report_mismatch("o_rd_rob_index", 32'($sampled(o_rd_rob_index)),
                             32'($sampled(m_rob[i_rd_idx])));
    a_we: assert property (@(posedge clk) disable iff (i_rst)
        m_busy[i_rd_idx] |-> o_rd_regf_we == m_we[i_rd_idx])
        else report_mismatch("o_rd_regf_we", 32'($sampled(o_rd_regf_we)),
                             32'($sampled(m_we[i_rd_idx])));
    a_aluc: assert property (@(posedge clk) disable iff (i_rst)
        m_busy[i_rd_idx] |-> o_rd_aluc == m_aluc[i_rd_idx])
        else report_mismatch("o_rd_aluc", 32'($sampled(o_rd_aluc)),
                             32'($sampled(m_aluc[i_rd_idx])));

    task automatic dispatch_inst(input logic [31:0] inst);
        logic [31:0] v;
        v = rand32();
        @(posedge clk);
        i_dispatch_valid <= 1'b1;
        i_inst <= inst;
        i_phys_rd <= v[5:0];
        i_phys_rs1 <= v[11:6];
        i_phys_rs2 <= v[17:12];
        i_rob_index <= v[21:18];
        @(posedge clk);
        i_dispatch_valid <= 1'b0;
    endtask

    task automatic remove_slot(input logic [3:0] idx);
        @(posedge clk);
        i_remove <= 1'b1;
        i_remove_idx <= idx;
        @(posedge clk);
        i_remove <= 1'b0;
    endtask

    task automatic flush_table();
        @(posedge clk);
        i_flush <= 1'b1;
        @(posedge clk);
        i_flush <= 1'b0;
    endtask

    // idle long enough for the read port to visit every slot
    task automatic end_test(input string name);
        repeat (DEPTH + 2) @(posedge clk);
        @(negedge clk);
        tests++;
        if (errors == test_start_errors)
            $display("test %0d %s: ok", tests, name);
        else
        begin
            failed_tests++;
            $display("test %0d %s: %0d mismatches", tests, name, errors - test_start_errors);
        end
        test_start_errors = errors;
    endtask

    initial
    begin
        i_rst = 1'b1;
        i_flush = 1'b0;
        i_dispatch_valid = 1'b0;
        i_remove = 1'b0;
        i_remove_idx = 4'd0;
        i_inst = 32'd0;
        i_phys_rd = 6'd0;
        i_phys_rs1 = 6'd0;
        i_phys_rs2 = 6'd0;
        i_rob_index = 4'd0;
        i_phys_valid = '0;
        repeat (8) @(posedge clk);
        i_rst <= 1'b0;
        end_test("reset state");

        dispatch_inst(make_inst(op_lui, 3'b000));
        dispatch_inst(make_inst(op_auipc, 3'b001));
        dispatch_inst(make_inst(op_jal, 3'b010));
        dispatch_inst(make_inst(op_jalr, 3'b000));
        // fence is outside the supported classes
        dispatch_inst(make_inst(7'b0001111, 3'b000));
        dispatch_inst(make_inst(op_branch, 3'b100));
        dispatch_inst(make_inst(op_load, 3'b010));
        dispatch_inst(make_inst(op_store, 3'b010));
        dispatch_inst(make_inst(op_imm, 3'b101));
        dispatch_inst(make_inst(op_imm, 3'b011));
        dispatch_inst(make_inst(op_reg, 3'b010));
        dispatch_inst(make_inst(op_reg, 3'b000));
        end_test("decode per class");

        flush_table();
        k = 4'd0;
        repeat (DEPTH)
        begin
            r = rand32();
            dispatch_inst(make_inst(fill_ops[k], r[2:0]));
            k = k + 4'd1;
        end
        dispatch_inst(make_inst(op_reg, 3'b000));
        end_test("fill to full");

        remove_slot(4'd9);
        remove_slot(4'd3);
        dispatch_inst(make_inst(op_imm, 3'b000));
        dispatch_inst(make_inst(op_branch, 3'b001));
        end_test("remove and refill");

        @(posedge clk);
        i_phys_valid <= '1;
        @(posedge clk);
        i_phys_valid <= '0;
        repeat (20)
        begin
            @(posedge clk);
            i_phys_valid <= {rand32(), rand32()};
        end
        end_test("readiness");

        flush_table();
        end_test("flush");

        $display("%0d tests run, %0d failed, %0d mismatches", tests, failed_tests, errors);
        if (errors == 0)
        begin
            $display("TEST PASSED");
        end
        else
        begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
verilog/rs_pkg.sv
verilog/rs_dispatch_decode.sv
verilog/rs_slot_alloc.sv
verilog/rs_entry_table.sv
verilog/reservation_station.sv
tb/tb_reservation_station.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_reservation_station -f tb.f -Mdir obj_dir -o sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST PASSED" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
